// ==== Bender.yml ====
package:
  name: shared_mem

sources:
  - mem_pkg.sv
  - mem_port_intf.sv
  - bank_resp_mux.sv
  - router_reorder.sv
  - router_addr_split.sv
  - mem_bank.sv
  - shared_mem_top.sv
  - target: test
    files:
      - tb_shared_mem_top.sv

// ==== bank_resp_mux.sv ====
/*
  Per-lane bank decoder for the reorder crossbar.
  Raises a one-hot bank request and picks the answering bank word one cycle later.
*/

`default_nettype none

module bank_resp_mux
  import mem_pkg::*;
#(
  parameter int unsigned NB_BANKS = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        req_i,
  input  logic                        gnt_i,
  input  logic [$clog2(NB_BANKS)-1:0] bank_i,
  output logic [NB_BANKS-1:0]         bank_req_o,
  input  data_t                       bank_rdata_i [NB_BANKS],
  output data_t                       rdata_o
);

  localparam int unsigned BANK_BITS = $clog2(NB_BANKS);

  // bank used by the last transfer of this lane
  logic [BANK_BITS-1:0] bank_q;

  // one-hot decode, all zero while idle
  always_comb begin
    bank_req_o = '0;
    if (req_i) begin
      bank_req_o[bank_i] = 1'b1;
    end
  end

  // remember the bank on a transfer only
  // a stalled group keeps the previous selection so an older response still lands right
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_q <= '0;
    end else if (clear_i) begin
      bank_q <= '0;
    end else if (req_i && gnt_i) begin
      bank_q <= bank_i;
    end
  end

  // banks hold r_data from their read register
  // so the word selected here belongs to the transfer one cycle back
  assign rdata_o = bank_rdata_i[bank_q];

endmodule

`default_nettype wire

// ==== compile.f ====
mem_pkg.sv
mem_port_intf.sv
bank_resp_mux.sv
router_reorder.sv
router_addr_split.sv
mem_bank.sv
shared_mem_top.sv
tb_shared_mem_top.sv

// ==== mem_bank.sv ====
/*
  Single-port synchronous SRAM bank with byte enables and one-cycle read latency.
  The stall input models contention from other masters by withholding the grant.
*/

`default_nettype none

module mem_bank
  import mem_pkg::*;
#(
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         stall_i,
  mem_port_intf.target port
);

  localparam int unsigned ROW_W  = $clog2(BANK_DEPTH);
  localparam int unsigned BYTE_W = DATA_W / STRB_W;

  data_t mem [BANK_DEPTH];
  data_t rdata_q;
  logic [ROW_W-1:0] row;
  logic transfer;

  // no arbitration here, the stall is the only reason to hold off
  assign port.gnt = ~stall_i;

  assign row      = port.add[ROW_W-1:0];
  assign transfer = port.req & port.gnt;

  // writes touch only the enabled bytes
  // a read loads the output register, kept until the next read
  always_ff @(posedge clk_i) begin
    if (transfer) begin
      if (port.wen) begin
        rdata_q <= mem[row];
      end else begin
        for (int b = 0; b < STRB_W; b++) begin
          if (port.be[b]) begin
            mem[row][b*BYTE_W +: BYTE_W] <= port.data[b*BYTE_W +: BYTE_W];
          end
        end
      end
    end
  end

  assign port.r_data = rdata_q;

  // upper address bits must be zero, else the row would alias
  a_row_in_depth : assert property (
    @(posedge clk_i) disable iff (!rst_ni) port.req |-> (port.add < addr_t'(BANK_DEPTH))
  ) else $error("bank row %0d out of depth %0d", port.add, BANK_DEPTH);

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
/*
  Shared word, byte-enable and address types for the interleaved shared memory.
  Imported by the port interface, the router stages, the banks and the top level.
*/

`default_nettype none

package mem_pkg;

  // one data word and its byte enables
  parameter int unsigned DATA_W = 32;
  parameter int unsigned STRB_W = DATA_W / 8;

  // byte address as seen by the accelerator port
  parameter int unsigned ADDR_W = 32;

  // byte-offset bits dropped to get a word index
  parameter int unsigned BYTE_OFFS = $clog2(STRB_W);

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== mem_port_intf.sv ====
/*
  Single memory port used between the router stages and the banks.
  Request side is the initiator, the memory side is the target.
*/

`default_nettype none

interface mem_port_intf
  import mem_pkg::*;
;

  // request channel, qualified by req
  logic  req;
  addr_t add;
  // high means read
  logic  wen;
  strb_t be;
  data_t data;

  // grant and read data, data valid one cycle after req & gnt
  logic  gnt;
  data_t r_data;

  modport initiator (
    output req,
    output add,
    output wen,
    output be,
    output data,
    input  gnt,
    input  r_data
  );

  modport target (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    output gnt,
    output r_data
  );

endinterface

`default_nettype wire

// ==== router_addr_split.sv ====
/*
  Splits a lane-group byte address into the rotation order and per-lane bank rows.
  Feeds the reorder crossbar and returns its grant and read words to the requester.
*/

`default_nettype none

module router_addr_split
  import mem_pkg::*;
#(
  parameter int unsigned NB_LANES   = 4,
  parameter int unsigned NB_BANKS   = 8,
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        wen_i,
  input  addr_t                       add_i,
  input  strb_t                       be_i     [NB_LANES],
  input  data_t                       data_i   [NB_LANES],
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output data_t                       r_data_o [NB_LANES],
  output logic [$clog2(NB_BANKS)-1:0] order_o,
  mem_port_intf.initiator             lanes    [NB_LANES]
);

  localparam int unsigned BANK_BITS = $clog2(NB_BANKS);
  localparam int unsigned WORD_W    = ADDR_W - BYTE_OFFS;

  logic [WORD_W-1:0] word;
  addr_t lane_row [NB_LANES];
  logic r_valid_q;

  // word index of the group base, low bits pick the first bank
  assign word    = add_i[ADDR_W-1:BYTE_OFFS];
  assign order_o = word[BANK_BITS-1:0];

  for (genvar i = 0; i < NB_LANES; i++) begin : gen_lane
    logic [WORD_W-1:0] lane_word;

    // a lane past the last bank carries into the next row
    assign lane_word   = word + WORD_W'(i);
    assign lane_row[i] = addr_t'(lane_word >> BANK_BITS);

    // same strobe and direction on every lane
    assign lanes[i].req  = req_i;
    assign lanes[i].wen  = wen_i;
    assign lanes[i].add  = lane_row[i];
    assign lanes[i].be   = be_i[i];
    assign lanes[i].data = data_i[i];
    assign r_data_o[i]   = lanes[i].r_data;

    a_row_in_range : assert property (
      @(posedge clk_i) disable iff (!rst_ni) req_i |-> (lane_row[i] < addr_t'(BANK_DEPTH))
    ) else $error("lane %0d row %0d beyond bank depth", i, lane_row[i]);
  end

  // lockstep grant comes back on lane 0
  assign gnt_o = lanes[0].gnt;

  // requester-side transfer flag, one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i & lanes[0].gnt;
    end
  end

  assign r_valid_o = r_valid_q;

endmodule

`default_nettype wire

// ==== router_reorder.sv ====
/*
  Rotating crossbar between a lane group and the interleaved banks.
  Lane i goes to bank (order + i) mod NB_BANKS; grant and response valid are lockstep.
*/

`default_nettype none

module router_reorder
  import mem_pkg::*;
#(
  parameter int unsigned NB_LANES             = 4,
  parameter int unsigned NB_BANKS             = 8,
  parameter int unsigned FILTER_WRITE_R_VALID = 0
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic [$clog2(NB_BANKS)-1:0] order_i,
  output logic                        r_valid_o,
  mem_port_intf.target                in  [NB_LANES],
  mem_port_intf.initiator             out [NB_BANKS]
);

  localparam int unsigned BANK_BITS = $clog2(NB_BANKS);

  // lane 0 carries req and wen for the whole group
  logic in_req;
  logic in_wen;
  addr_t in_add   [NB_LANES];
  strb_t in_be    [NB_LANES];
  data_t in_data  [NB_LANES];
  data_t in_rdata [NB_LANES];

  // one-hot bank request per lane
  logic [NB_BANKS-1:0] lane_bank_req [NB_LANES];

  logic [NB_BANKS-1:0] out_req;
  logic [NB_BANKS-1:0] out_gnt;
  data_t out_rdata [NB_BANKS];

  logic grant;
  logic r_valid_d;
  logic r_valid_q;

  assign in_req = in[0].req;
  assign in_wen = in[0].wen;

  // every requested bank must grant in the same cycle for the group grant
  assign grant = &(~out_req | out_gnt);

  for (genvar i = 0; i < NB_LANES; i++) begin : gen_lane
    logic [BANK_BITS-1:0] lane_bank;

    // rotation wraps by truncation since NB_BANKS is a power of two
    assign lane_bank = order_i + BANK_BITS'(i);

    bank_resp_mux #(
      .NB_BANKS (NB_BANKS)
    ) u_resp_mux (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .clear_i      (clear_i),
      .req_i        (in_req),
      .gnt_i        (grant),
      .bank_i       (lane_bank),
      .bank_req_o   (lane_bank_req[i]),
      .bank_rdata_i (out_rdata),
      .rdata_o      (in_rdata[i])
    );

    assign in_add[i]    = in[i].add;
    assign in_be[i]     = in[i].be;
    assign in_data[i]   = in[i].data;
    assign in[i].r_data = in_rdata[i];

    // grant is reported on lane 0 only
    if (i == 0) begin : gen_gnt
      assign in[i].gnt = grant;
    end else begin : gen_no_gnt
      assign in[i].gnt = 1'b0;
    end
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    logic [NB_LANES-1:0] sel;
    addr_t add_sel;
    strb_t be_sel;
    data_t data_sel;

    // AND-OR steering since at most one lane hits this bank
    always_comb begin
      sel      = '0;
      add_sel  = '0;
      be_sel   = '0;
      data_sel = '0;
      for (int j = 0; j < NB_LANES; j++) begin
        sel[j]   = lane_bank_req[j][b];
        add_sel  = add_sel | (sel[j] ? in_add[j] : '0);
        be_sel   = be_sel | (sel[j] ? in_be[j] : '0);
        data_sel = data_sel | (sel[j] ? in_data[j] : '0);
      end
    end

    assign out_req[b]   = |sel;
    // a bank sees the request only once the whole group is granted
    assign out[b].req   = out_req[b] & grant;
    assign out[b].add   = add_sel;
    assign out[b].wen   = in_wen;
    assign out[b].be    = be_sel;
    assign out[b].data  = data_sel;
    assign out_gnt[b]   = out[b].gnt;
    assign out_rdata[b] = out[b].r_data;

    // rotation must map lanes to distinct banks
    a_bank_single_lane : assert property (
      @(posedge clk_i) disable iff (!rst_ni) $onehot0(sel)
    ) else $error("bank %0d requested by more than one lane", b);
  end

  // fixed latency of one with writes optionally dropped
  assign r_valid_d = in_req & grant & ((FILTER_WRITE_R_VALID != 0) ? in_wen : 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (clear_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= r_valid_d;
    end
  end

  assign r_valid_o = r_valid_q;

endmodule

`default_nettype wire

// ==== shared_mem_top.sv ====
/*
  Word-interleaved shared memory behind one wide accelerator port.
  Address splitter, reorder crossbar and NB_BANKS single-port banks.
*/

`default_nettype none

module shared_mem_top
  import mem_pkg::*;
#(
  parameter int unsigned NB_LANES             = 4,
  parameter int unsigned NB_BANKS             = 8,
  parameter int unsigned BANK_DEPTH           = 64,
  parameter int unsigned FILTER_WRITE_R_VALID = 0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                req_i,
  input  logic                wen_i,
  input  addr_t               add_i,
  input  strb_t               be_i         [NB_LANES],
  input  data_t               data_i       [NB_LANES],
  input  logic [NB_BANKS-1:0] bank_stall_i,
  output logic                gnt_o,
  output logic                r_valid_o,
  output data_t               r_data_o     [NB_LANES]
);

  localparam int unsigned BANK_BITS = $clog2(NB_BANKS);

  // rotation of the current group
  logic [BANK_BITS-1:0] order;

  mem_port_intf lane_ports [NB_LANES] ();
  mem_port_intf bank_ports [NB_BANKS] ();

  router_addr_split #(
    .NB_LANES   (NB_LANES),
    .NB_BANKS   (NB_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) u_addr_split (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .wen_i     (wen_i),
    .add_i     (add_i),
    .be_i      (be_i),
    .data_i    (data_i),
    .gnt_o     (gnt_o),
    .r_valid_o (),
    .r_data_o  (r_data_o),
    .order_o   (order),
    .lanes     (lane_ports)
  );

  // response valid comes from the crossbar, which honours clear and the write filter
  router_reorder #(
    .NB_LANES             (NB_LANES),
    .NB_BANKS             (NB_BANKS),
    .FILTER_WRITE_R_VALID (FILTER_WRITE_R_VALID)
  ) u_reorder (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .order_i   (order),
    .r_valid_o (r_valid_o),
    .in        (lane_ports),
    .out       (bank_ports)
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    mem_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .stall_i (bank_stall_i[b]),
      .port    (bank_ports[b])
    );
  end

endmodule

`default_nettype wire

// ==== tb_shared_mem_top.sv ====
/*
  Testbench for the interleaved shared memory with a flat word reference model.
  Drives lane groups on the falling edge while concurrent assertions check grant, valid and data.
*/

`default_nettype none

module tb_shared_mem_top
  import mem_pkg::*;
;

  localparam int unsigned NB_LANES    = 4;
  localparam int unsigned NB_BANKS    = 8;
  localparam int unsigned BANK_DEPTH  = 64;
  localparam int unsigned TOTAL_WORDS = NB_BANKS * BANK_DEPTH;
  localparam int unsigned NB_RAND     = 8;
  // preload, then per-test request counts with a few idle cycles each
  localparam int unsigned TEST_CYCLES = 4 + TOTAL_WORDS / NB_LANES + 2 + 2 * NB_BANKS + 2
                                      + NB_RAND + 2 + 2 * NB_RAND + 2 + 16 + 8;
  localparam int unsigned CYCLE_LIMIT = TEST_CYCLES + 50;

  logic clk_i, rst_ni, clear_i, req_i, wen_i, gnt_o, r_valid_o;
  addr_t add_i;
  strb_t be_i [NB_LANES];
  data_t data_i [NB_LANES];
  data_t r_data_o [NB_LANES];
  logic [NB_BANKS-1:0] bank_stall_i;

  // reference memory indexed by flat word index, plus the expected response
  data_t ref_mem [TOTAL_WORDS];
  data_t exp_data [NB_LANES];
  logic exp_valid, exp_read, exp_gnt;
  data_t wr_data [NB_LANES];
  strb_t wr_be [NB_LANES];

  integer seed = 92760;
  int unsigned cycle_count = 0;
  int unsigned err_count = 0;
  int unsigned err_at_start, pass_count = 0, fail_count = 0;

  shared_mem_top u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .req_i        (req_i),
    .wen_i        (wen_i),
    .add_i        (add_i),
    .be_i         (be_i),
    .data_i       (data_i),
    .bank_stall_i (bank_stall_i),
    .gnt_o        (gnt_o),
    .r_valid_o    (r_valid_o),
    .r_data_o     (r_data_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // group grant expected from the stall inputs of the banks the group touches
  always_comb begin : grant_model
    int unsigned w;
    w = add_i >> BYTE_OFFS;
    exp_gnt = 1'b1;
    for (int i = 0; i < NB_LANES; i++) begin
      if (bank_stall_i[(w + i) % NB_BANKS]) exp_gnt = 1'b0;
    end
  end

  // model update on each transfer where reads capture the words before any change
  always @(posedge clk_i or negedge rst_ni) begin : model_update
    int unsigned w;
    if (!rst_ni) begin
      exp_valid <= 1'b0;
      exp_read  <= 1'b0;
    end else begin
      w = add_i >> BYTE_OFFS;
      exp_valid <= req_i && exp_gnt && !clear_i;
      exp_read  <= wen_i;
      if (req_i && exp_gnt) begin
        for (int i = 0; i < NB_LANES; i++) begin
          if (wen_i) begin
            exp_data[i] <= ref_mem[w + i];
          end else begin
            for (int b = 0; b < STRB_W; b++) begin
              if (be_i[i][b]) ref_mem[w + i][b*8 +: 8] = data_i[i][b*8 +: 8];
            end
          end
        end
      end
    end
  end

  a_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni) req_i |-> gnt_o == exp_gnt)
    else begin
      $display("error t=%0t gnt_o expected %0b got %0b", $time, $sampled(exp_gnt),
               $sampled(gnt_o));
      err_count++;
    end

  a_r_valid : assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid_o == exp_valid)
    else begin
      $display("error t=%0t r_valid_o expected %0b got %0b", $time, $sampled(exp_valid),
               $sampled(r_valid_o));
      err_count++;
    end

  for (genvar i = 0; i < NB_LANES; i++) begin : gen_lane_chk
    a_r_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (exp_valid && exp_read) |-> r_data_o[i] == exp_data[i])
      else begin
        $display("error t=%0t r_data_o[%0d] expected %h got %h", $time, i,
                 $sampled(exp_data[i]), $sampled(r_data_o[i]));
        err_count++;
      end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: no end of run after %0d cycles, a grant probably never came",
               CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // fill value mixes every bit of the word index
  function automatic data_t fill_word(input int unsigned w);
    return (data_t'(w) * 32'h0100_0193) ^ {~data_t'(w)} << 7 ^ 32'hc3a5_5a3c;
  endfunction

  // drive one group and hold it until granted with the stall lifted after hold cycles
  task automatic send(input logic wen, input int unsigned word, input logic clr,
                      input logic [NB_BANKS-1:0] stall, input int unsigned hold);
    req_i = 1'b1;
    wen_i = wen;
    add_i = addr_t'(word << BYTE_OFFS);
    clear_i = clr;
    bank_stall_i = stall;
    for (int k = 0; k < NB_LANES; k++) begin
      be_i[k]   = wr_be[k];
      data_i[k] = wr_data[k];
    end
    repeat (hold) @(negedge clk_i);
    if (hold != 0) bank_stall_i = '0;
    do @(posedge clk_i); while (!gnt_o);
    @(negedge clk_i);
    clear_i = 1'b0;
    bank_stall_i = '0;
  endtask

  task automatic go_idle(input int unsigned n);
    req_i = 1'b0;
    clear_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  task automatic set_write(input logic partial);
    for (int k = 0; k < NB_LANES; k++) begin
      wr_data[k] = $random(seed);
      wr_be[k]   = partial ? strb_t'($random(seed)) : '1;
    end
  endtask

  task automatic start_test();
    err_at_start = err_count;
  endtask

  task automatic finish_test(input string name);
    go_idle(2);
    if (err_count == err_at_start) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d mismatches", name, err_count - err_at_start);
    end
  endtask

  initial begin
    int unsigned w;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    req_i = 1'b0;
    wen_i = 1'b1;
    add_i = '0;
    bank_stall_i = '0;
    for (int k = 0; k < NB_LANES; k++) begin
      be_i[k] = '0;
      data_i[k] = '0;
      wr_be[k] = '1;
    end
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test();
    go_idle(2);
    finish_test("reset r_valid_o low");

    // preload all words, then write and read back once per rotation order
    start_test();
    for (w = 0; w < TOTAL_WORDS; w += NB_LANES) begin
      for (int k = 0; k < NB_LANES; k++) wr_data[k] = fill_word(w + k);
      send(1'b0, w, 1'b0, '0, 0);
    end
    for (int o = 0; o < NB_BANKS; o++) begin
      w = pick(BANK_DEPTH - 1) * NB_BANKS + o;
      set_write(1'b0);
      send(1'b0, w, 1'b0, '0, 0);
      send(1'b1, w, 1'b0, '0, 0);
    end
    finish_test("full writes over all orders");

    // one read per cycle keeps two groups in flight
    start_test();
    for (int n = 0; n < NB_RAND; n++) send(1'b1, pick(TOTAL_WORDS - NB_LANES + 1), 1'b0, '0, 0);
    finish_test("back-to-back reads");

    start_test();
    for (int n = 0; n < NB_RAND; n++) begin
      w = pick(TOTAL_WORDS - NB_LANES + 1);
      set_write(1'b1);
      send(1'b0, w, 1'b0, '0, 0);
      send(1'b1, w, 1'b0, '0, 0);
    end
    finish_test("partial writes");

    // stall a targeted bank, then stall only banks outside the group
    start_test();
    w = pick(TOTAL_WORDS - NB_LANES + 1);
    set_write(1'b0);
    send(1'b0, w, 1'b0, NB_BANKS'(1) << ((w + 2) % NB_BANKS), 3);
    send(1'b1, w, 1'b0, NB_BANKS'(1) << (w % NB_BANKS), 2);
    send(1'b1, w, 1'b0, NB_BANKS'(1) << ((w + NB_LANES) % NB_BANKS), 0);
    finish_test("bank stall");

    // writes are answered too and a clear with the grant drops the response
    start_test();
    w = pick(TOTAL_WORDS - NB_LANES + 1);
    set_write(1'b0);
    send(1'b0, w, 1'b0, '0, 0);
    send(1'b1, w, 1'b1, '0, 0);
    send(1'b1, w, 1'b0, '0, 0);
    finish_test("r_valid_o and clear");

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
